// ==== rtl/serial_io_pkg.sv ====
// Shared definitions for the memory-mapped serial I/O peripheral.
// Holds the processor-side address map, the bit layout of the status
// word and the byte and word types used by RTL and testbench alike.
// Import with serial_io_pkg::* in the module header where needed.

package serial_io_pkg;

    // ---------------------------------------------------------------------
    // Data types
    // ---------------------------------------------------------------------

    // One serial data byte
    typedef logic [7:0] byte_t;

    // Processor bus address or data word
    typedef logic [31:0] io_word_t;

    // ---------------------------------------------------------------------
    // Address map
    // ---------------------------------------------------------------------

    // Status word, read only; a load clears the overrun flag
    localparam io_word_t STATUS_ADDR = 32'h8000_0000;

    // Receive data, a load pops one byte from the FIFO
    localparam io_word_t RX_DATA_ADDR = 32'h8000_0004;

    // Transmit data, a store sends wdata[7:0]
    localparam io_word_t TX_DATA_ADDR = 32'h8000_0008;

    // ---------------------------------------------------------------------
    // Status word bit positions
    // ---------------------------------------------------------------------

    // Transmitter idle and able to take a byte
    localparam int STAT_TX_READY = 0;
    // At least one received byte waiting
    localparam int STAT_RX_VALID = 1;
    // Sticky, a received byte was lost
    localparam int STAT_RX_OVERRUN = 2;

endpackage

// ==== rtl/uart_tx.sv ====
// UART transmitter, 8 data bits, no parity, one stop bit.
// Takes one byte per valid/ready transfer and shifts out the frame
// LSB first. The line falls one cycle after the accepted transfer and
// ready returns the cycle after the stop bit has finished.

`timescale 1ns/100ps

module uart_tx
    import serial_io_pkg::*;
#(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE  = 115_200
)
(
    input  logic  Clock,
    input  logic  rst_n,
    input  byte_t data,
    input  logic  valid,
    output logic  ready,
    output logic  serial_out
);

    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    // Frame bits still to go out, stop and data and start
    logic [9:0]       shift_reg;
    logic [3:0]       bits_left;
    logic [CNT_W-1:0] clk_cnt;
    logic             busy;

    assign ready      = ~busy;
    // Idle shift register is all ones, so the line rests high
    assign serial_out = shift_reg[0];

    always_ff @(posedge Clock)
    begin
        if (!rst_n)
        begin
            shift_reg <= '1;
            bits_left <= '0;
            clk_cnt   <= '0;
            busy      <= 1'b0;
        end
        else if (!busy)
        begin
            if (valid)
            begin
                // Stop bit, data, start bit
                shift_reg <= {1'b1, data, 1'b0};
                bits_left <= 4'd10;
                clk_cnt   <= '0;
                busy      <= 1'b1;
            end
        end
        else
        begin
            if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1))
            begin
                clk_cnt   <= '0;
                shift_reg <= {1'b1, shift_reg[9:1]};
                bits_left <= bits_left - 4'd1;
                // Last period was the stop bit
                if (bits_left == 4'd1)
                begin
                    busy <= 1'b0;
                end
            end
            else
            begin
                clk_cnt <= clk_cnt + CNT_W'(1);
            end
        end
    end

endmodule

// ==== rtl/uart_rx.sv ====
// UART receiver, 8 data bits, no parity, one stop bit.
// Expects an already synchronized serial line. Finds the start edge,
// confirms it at mid-bit, samples the data bits at mid-bit and checks
// the stop bit. Good bytes are offered with valid/ready; a byte that
// completes while ready is low is lost and drop pulses for one cycle.

`timescale 1ns/100ps

module uart_rx
    import serial_io_pkg::*;
#(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE  = 115_200
)
(
    input  logic  Clock,
    input  logic  rst_n,
    input  logic  serial_in,
    output byte_t data,
    output logic  valid,
    input  logic  ready,
    output logic  drop
);

    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_reg;
    logic             serial_prev;

    always_ff @(posedge Clock)
    begin
        if (!rst_n)
        begin
            state       <= RX_IDLE;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            serial_prev <= 1'b1;
            valid       <= 1'b0;
            drop        <= 1'b0;
        end
        else
        begin
            serial_prev <= serial_in;
            drop        <= 1'b0;

            // Pending byte taken by the consumer
            if (valid && ready)
            begin
                valid <= 1'b0;
            end

            case (state)
                RX_IDLE:
                begin
                    clk_cnt <= '0;
                    if (serial_prev && !serial_in)
                    begin
                        state <= RX_START;
                    end
                end
                RX_START:
                begin
                    if (clk_cnt == CNT_W'(HALF_BIT - 1))
                    begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch rather than a real start bit
                        state   <= serial_in ? RX_IDLE : RX_DATA;
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                RX_DATA:
                begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1))
                    begin
                        clk_cnt   <= '0;
                        shift_reg <= {serial_in, shift_reg[7:1]};
                        bit_idx   <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                        begin
                            state <= RX_STOP;
                        end
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                RX_STOP:
                begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1))
                    begin
                        clk_cnt <= '0;
                        state   <= RX_IDLE;
                        // Low stop bit, frame thrown away
                        if (serial_in)
                        begin
                            if (ready)
                            begin
                                data  <= shift_reg;
                                valid <= 1'b1;
                            end
                            else
                            begin
                                drop <= 1'b1;
                                // Newer byte overwrites a stalled one
                                if (valid)
                                begin
                                    data <= shift_reg;
                                end
                            end
                        end
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                default:
                begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/uart.sv ====
// UART wrapper pairing the transmit and receive engines.
// Brings the asynchronous serial input into the clock domain through
// two flops and passes the byte handshakes straight to each engine.

`timescale 1ns/100ps

module uart
    import serial_io_pkg::*;
#(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE  = 115_200
)
(
    input  logic  Clock,
    input  logic  rst_n,
    input  byte_t tx_data,
    input  logic  tx_valid,
    output logic  tx_ready,
    output byte_t rx_data,
    output logic  rx_valid,
    input  logic  rx_ready,
    output logic  rx_drop,
    input  logic  serial_in,
    output logic  serial_out
);

    logic serial_meta;
    logic serial_sync;

    // Two-flop synchronizer, reset to the idle line level
    always_ff @(posedge Clock)
    begin
        if (!rst_n)
        begin
            serial_meta <= 1'b1;
            serial_sync <= 1'b1;
        end
        else
        begin
            serial_meta <= serial_in;
            serial_sync <= serial_meta;
        end
    end

    uart_tx #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) uart_tx_inst (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .data       (tx_data),
        .valid      (tx_valid),
        .ready      (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) uart_rx_inst (
        .Clock     (Clock),
        .rst_n     (rst_n),
        .serial_in (serial_sync),
        .data      (rx_data),
        .valid     (rx_valid),
        .ready     (rx_ready),
        .drop      (rx_drop)
    );

endmodule

// ==== rtl/rx_byte_fifo.sv ====
// Small synchronous FIFO for received bytes.
// Circular buffer with read and write pointers and an occupancy count.
// The oldest entry is visible on pop_data without a pop. When full, a
// push in the same cycle as a pop is still accepted.

`timescale 1ns/100ps

module rx_byte_fifo
    import serial_io_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic  Clock,
    input  logic  rst_n,
    input  logic  push,
    input  byte_t push_data,
    input  logic  pop,
    output byte_t pop_data,
    output logic  empty,
    output logic  full
);

    localparam int AW = $clog2(DEPTH);

    byte_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign empty    = (count == '0);
    assign full     = (count == (AW+1)'(DEPTH));
    assign do_pop   = pop && !empty;
    assign do_push  = push && (!full || do_pop);
    assign pop_data = mem[rd_ptr];

    // Storage, no reset needed
    always_ff @(posedge Clock)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + (AW+1)'(1);
                2'b01:   count <= count - (AW+1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/io_bus_interface.sv ====
// Processor bus side of the serial peripheral.
// Decodes loads and stores to the status, receive and transmit
// addresses, drives the byte handshakes toward the UART, buffers
// received bytes and returns registered read data one cycle after the
// load strobe. Unmapped loads and empty receive reads return zero.

`timescale 1ns/100ps

module io_bus_interface
    import serial_io_pkg::*;
#(
    parameter int RX_FIFO_DEPTH = 4
)
(
    input  logic     Clock,
    input  logic     rst_n,
    input  io_word_t addr,
    input  io_word_t wdata,
    input  logic     store,
    input  logic     load,
    output io_word_t rdata,
    output byte_t    tx_data,
    output logic     tx_valid,
    input  logic     tx_ready,
    input  byte_t    rx_data,
    input  logic     rx_valid,
    output logic     rx_ready,
    input  logic     rx_drop
);

    logic     sel_status;
    logic     sel_rx;
    logic     sel_tx;
    logic     fifo_push;
    logic     fifo_pop;
    byte_t    fifo_data;
    logic     fifo_empty;
    logic     fifo_full;
    logic     overrun;
    io_word_t status_word;

    // -------------------------------------------------------------------
    // Address decode and handshakes
    // -------------------------------------------------------------------

    assign sel_status = (addr == STATUS_ADDR);
    assign sel_rx     = (addr == RX_DATA_ADDR);
    assign sel_tx     = (addr == TX_DATA_ADDR);

    // Store while the transmitter is busy is simply lost
    assign tx_data  = wdata[7:0];
    assign tx_valid = store && sel_tx && tx_ready;

    assign rx_ready  = ~fifo_full;
    assign fifo_push = rx_valid && rx_ready;
    assign fifo_pop  = load && sel_rx && !fifo_empty;

    rx_byte_fifo #(
        .DEPTH     (RX_FIFO_DEPTH)
    ) rx_byte_fifo_inst (
        .Clock     (Clock),
        .rst_n     (rst_n),
        .push      (fifo_push),
        .push_data (rx_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    // -------------------------------------------------------------------
    // Status and read data
    // -------------------------------------------------------------------

    always_comb
    begin
        status_word                  = '0;
        status_word[STAT_TX_READY]   = tx_ready;
        status_word[STAT_RX_VALID]   = ~fifo_empty;
        status_word[STAT_RX_OVERRUN] = overrun;
    end

    // Sticky overrun; a drop in the same cycle as a status read wins
    always_ff @(posedge Clock)
    begin
        if (!rst_n)
        begin
            overrun <= 1'b0;
        end
        else if (rx_drop)
        begin
            overrun <= 1'b1;
        end
        else if (load && sel_status)
        begin
            overrun <= 1'b0;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (!rst_n)
        begin
            rdata <= '0;
        end
        else if (load)
        begin
            if (sel_status)
            begin
                rdata <= status_word;
            end
            else if (sel_rx && !fifo_empty)
            begin
                rdata <= {24'b0, fifo_data};
            end
            else
            begin
                rdata <= '0;
            end
        end
    end

endmodule

// ==== rtl/serial_io_top.sv ====
// Top level of the memory-mapped serial I/O peripheral.
// Connects the processor bus to the bus interface, the byte handshakes
// between bus interface and UART, and the serial pins to the UART.
// Clock rate, baud rate and receive FIFO depth are set here.

`timescale 1ns/100ps

module serial_io_top
    import serial_io_pkg::*;
#(
    parameter int CLOCK_FREQ    = 50_000_000,
    parameter int BAUD_RATE     = 115_200,
    parameter int RX_FIFO_DEPTH = 4
)
(
    input  logic     Clock,
    input  logic     rst_n,
    input  io_word_t addr,
    input  io_word_t wdata,
    input  logic     store,
    input  logic     load,
    output io_word_t rdata,
    input  logic     serial_in,
    output logic     serial_out
);

    byte_t tx_data;
    logic  tx_valid;
    logic  tx_ready;
    byte_t rx_data;
    logic  rx_valid;
    logic  rx_ready;
    logic  rx_drop;

    io_bus_interface #(
        .RX_FIFO_DEPTH (RX_FIFO_DEPTH)
    ) io_bus_interface_inst (
        .Clock    (Clock),
        .rst_n    (rst_n),
        .addr     (addr),
        .wdata    (wdata),
        .store    (store),
        .load     (load),
        .rdata    (rdata),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_drop  (rx_drop)
    );

    uart #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) uart_inst (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_drop    (rx_drop),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

endmodule

// ==== verification/serial_io_asserts.sv ====
// Concurrent checks on the bus side of the serial peripheral.
// Bound into io_bus_interface, so they watch the processor strobes,
// both byte handshakes toward the UART and the registered read data.

`timescale 1ns/100ps

module serial_io_asserts
    import serial_io_pkg::*;
(
    input logic     Clock,
    input logic     rst_n,
    input logic     store,
    input logic     load,
    input io_word_t rdata,
    input logic     tx_valid,
    input logic     tx_ready,
    input logic     rx_valid,
    input logic     rx_ready
);

    // Processor never loads and stores at once
    store_load_exclusive: assert property (
        @(posedge Clock) disable iff (!rst_n)
        !(store && load)
    )
    else $error("store and load high in the same cycle");

    // Transfer only to an idle transmitter, which then goes busy
    tx_valid_needs_ready: assert property (
        @(posedge Clock) disable iff (!rst_n)
        tx_valid |-> tx_ready ##1 !tx_ready
    )
    else $error("tx_valid without tx_ready, or tx_ready still high after the transfer");

    // Pending received byte stays offered until taken
    rx_valid_held: assert property (
        @(posedge Clock) disable iff (!rst_n)
        (rx_valid && !rx_ready) |=> rx_valid
    )
    else $error("rx_valid fell before rx_ready");

    // First cycle out of reset
    rdata_clear_after_reset: assert property (
        @(posedge Clock)
        $rose(rst_n) |-> (rdata == '0)
    )
    else $error("rdata not zero in the cycle after reset");

endmodule

bind io_bus_interface serial_io_asserts serial_io_asserts_inst (
    .Clock    (Clock),
    .rst_n    (rst_n),
    .store    (store),
    .load     (load),
    .rdata    (rdata),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready)
);

// ==== verification/serial_io_tb.sv ====
// Loopback testbench for the memory-mapped serial I/O peripheral.
// serial_out drives serial_in directly, so each byte stored to the
// transmit register should come back through the receive FIFO.
// A table of bus operations is built at start, applied in a loop,
// and every load is compared with the value the table expects.

`timescale 1ns/100ps

module serial_io_tb
    import serial_io_pkg::*;
();

    localparam int       CLOCK_FREQ    = 50_000_000;
    localparam int       BAUD_RATE     = 3_125_000;
    localparam int       FIFO_DEPTH    = 4;
    localparam io_word_t UNMAPPED_ADDR = 32'h8000_000C;

    // Status word masks
    localparam io_word_t ST_TX  = io_word_t'(1) << STAT_TX_READY;
    localparam io_word_t ST_RXV = io_word_t'(1) << STAT_RX_VALID;
    localparam io_word_t ST_OVR = io_word_t'(1) << STAT_RX_OVERRUN;

    typedef enum logic [1:0] {OP_STORE, OP_LOAD, OP_WAIT} op_kind_t;

    // Wait entries poll addr until (rdata & data) == expected
    typedef struct packed {
        op_kind_t kind;
        io_word_t addr;
        io_word_t data;
        io_word_t expected;
    } op_t;

    logic     Clock;
    logic     rst_n;
    io_word_t addr;
    io_word_t wdata;
    logic     store;
    logic     load;
    io_word_t rdata;
    logic     serial_line;

    op_t ops [$];
    int  checks      = 0;
    int  errors      = 0;
    int  cycles      = 0;
    int  cycle_limit = 0;

    serial_io_top #(
        .CLOCK_FREQ    (CLOCK_FREQ),
        .BAUD_RATE     (BAUD_RATE),
        .RX_FIFO_DEPTH (FIFO_DEPTH)
    ) serial_io_top_inst (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .addr       (addr),
        .wdata      (wdata),
        .store      (store),
        .load       (load),
        .rdata      (rdata),
        .serial_in  (serial_line),
        .serial_out (serial_line)
    );

    always #10 Clock = ~Clock;

    always @(posedge Clock)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the DUT never reached the awaited state",
                     cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ---------------------------------------------------------------------
    // Table construction
    // ---------------------------------------------------------------------

    task automatic add_op(input op_kind_t kind, input io_word_t a, input io_word_t d,
                          input io_word_t e);
        op_t op;
        op.kind     = kind;
        op.addr     = a;
        op.data     = d;
        op.expected = e;
        ops.push_back(op);
    endtask

    task automatic wait_status(input io_word_t mask, input io_word_t want);
        add_op(OP_WAIT, STATUS_ADDR, mask, want);
    endtask

    task automatic read_expect(input io_word_t a, input io_word_t e);
        add_op(OP_LOAD, a, '0, e);
    endtask

    // Software polls the transmitter before every store
    task automatic send_byte(input byte_t b);
        wait_status(ST_TX, ST_TX);
        add_op(OP_STORE, TX_DATA_ADDR, {24'b0, b}, '0);
    endtask

    task automatic build_table();
        byte_t fifo_bytes [4];
        byte_t burst_bytes [5];
        byte_t kept_byte;
        byte_t ignored_byte;
        foreach (fifo_bytes[i])
        begin
            fifo_bytes[i] = byte_t'($urandom);
        end
        foreach (burst_bytes[i])
        begin
            burst_bytes[i] = byte_t'($urandom);
        end
        kept_byte    = byte_t'($urandom);
        ignored_byte = byte_t'($urandom);

        // Reset state
        read_expect(STATUS_ADDR, ST_TX);
        read_expect(RX_DATA_ADDR, '0);

        // Single byte loopback
        send_byte(8'h5A);
        wait_status(ST_TX | ST_RXV, ST_TX | ST_RXV);
        read_expect(RX_DATA_ADDR, 32'h0000_005A);
        read_expect(STATUS_ADDR, ST_TX);

        // Four bytes come back in the order sent
        foreach (fifo_bytes[i])
        begin
            send_byte(fifo_bytes[i]);
        end
        wait_status(ST_TX | ST_RXV, ST_TX | ST_RXV);
        foreach (fifo_bytes[i])
        begin
            read_expect(RX_DATA_ADDR, {24'b0, fifo_bytes[i]});
        end
        read_expect(STATUS_ADDR, ST_TX);

        // Fifth byte finds the FIFO full and is lost
        foreach (burst_bytes[i])
        begin
            send_byte(burst_bytes[i]);
        end
        wait_status(ST_RXV | ST_OVR, ST_RXV | ST_OVR);
        wait_status(ST_TX, ST_TX);
        read_expect(STATUS_ADDR, ST_TX | ST_RXV);
        for (int i = 0; i < 4; i++)
        begin
            read_expect(RX_DATA_ADDR, {24'b0, burst_bytes[i]});
        end
        read_expect(RX_DATA_ADDR, '0);

        // Second store lands while the transmitter is busy
        send_byte(kept_byte);
        add_op(OP_STORE, TX_DATA_ADDR, {24'b0, ignored_byte}, '0);
        wait_status(ST_TX | ST_RXV, ST_TX | ST_RXV);
        read_expect(RX_DATA_ADDR, {24'b0, kept_byte});
        read_expect(RX_DATA_ADDR, '0);

        // Status first so rdata is nonzero before each unmapped load
        read_expect(STATUS_ADDR, ST_TX);
        read_expect(UNMAPPED_ADDR, '0);
        read_expect(STATUS_ADDR, ST_TX);
        read_expect(32'h0000_0000, '0);
    endtask

    // ---------------------------------------------------------------------
    // Bus access and checking
    // ---------------------------------------------------------------------

    task automatic drive_store(input io_word_t a, input io_word_t d);
        addr  = a;
        wdata = d;
        store = 1'b1;
        @(negedge Clock);
        store = 1'b0;
    endtask

    // rdata is registered, so it is read one falling edge later
    task automatic bus_load(input io_word_t a, output io_word_t value);
        addr = a;
        load = 1'b1;
        @(negedge Clock);
        load  = 1'b0;
        value = rdata;
    endtask

    task automatic poll_status(input io_word_t a, input io_word_t mask, input io_word_t want);
        io_word_t value;
        bus_load(a, value);
        while ((value & mask) != want)
        begin
            bus_load(a, value);
        end
    endtask

    task automatic check_value(input int entry, input io_word_t exp, input io_word_t got);
        checks = checks + 1;
        if (got !== exp)
        begin
            errors = errors + 1;
            $display("FAIL time=%0t signal=rdata entry=%0d expected=0x%08h actual=0x%08h",
                     $time, entry, exp, got);
        end
    endtask

    initial
    begin
        op_t      op;
        io_word_t value;
        void'($urandom(47563));
        Clock = 1'b0;
        rst_n = 1'b0;
        addr  = '0;
        wdata = '0;
        store = 1'b0;
        load  = 1'b0;

        build_table();
        cycle_limit = ops.size() * 200 + 2000;

        repeat (8) @(negedge Clock);
        rst_n = 1'b1;
        @(negedge Clock);

        // Transmit line idles high out of reset
        checks = checks + 1;
        if (serial_line !== 1'b1)
        begin
            errors = errors + 1;
            $display("FAIL time=%0t signal=serial_out expected=1 actual=%b",
                     $time, serial_line);
        end

        foreach (ops[i])
        begin
            op = ops[i];
            case (op.kind)
                OP_STORE:
                begin
                    drive_store(op.addr, op.data);
                end
                OP_LOAD:
                begin
                    bus_load(op.addr, value);
                    check_value(i, op.expected, value);
                end
                default:
                begin
                    poll_status(op.addr, op.data, op.expected);
                end
            endcase
        end

        $display("Summary: %0d table entries, %0d checks, %0d errors",
                 ops.size(), checks, errors);
        if (errors == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/serial_io_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart.sv
rtl/rx_byte_fifo.sv
rtl/io_bus_interface.sv
rtl/serial_io_top.sv
verification/serial_io_asserts.sv
verification/serial_io_tb.sv
